// ==== hdl/accel_pkg.sv ====
// Shared definitions for the matrix-tile accelerator
// Widths, array geometry, command and state encodings

package accel_pkg;

    // ====================
    // Widths and geometry
    // ====================
    localparam int DATA_W = 8;
    localparam int ACC_W  = 32;

    localparam int N_ROWS = 2;
    localparam int N_COLS = 2;

    localparam int BUF_DEPTH = 16;
    localparam int BUF_AW    = $clog2(BUF_DEPTH);

    // Credits granted to the response sender out of reset
    localparam int TX_CREDITS_INIT = 4;

    // Register map
    localparam logic [7:0] CSR_K_LEN     = 8'h00;
    localparam logic [7:0] CSR_RUN_COUNT = 8'h01;

    // ====================
    // Encodings
    // ====================
    // Upper nibble of the command byte, 8..F unused
    typedef enum logic [3:0] {
        CMD_CSR_WR   = 4'h0,
        CMD_CSR_RD   = 4'h1,
        CMD_BUF_WR_A = 4'h2,
        CMD_BUF_WR_B = 4'h3,
        CMD_RD_OUT   = 4'h4,
        CMD_START    = 4'h5,
        CMD_ABORT    = 4'h6,
        CMD_STATUS   = 4'h7
    } cmd_e;

    // One parser state per byte position
    typedef enum logic [2:0] {
        RX_CMD,
        RX_ADDR_L,
        RX_ADDR_H,
        RX_DATA0,
        RX_DATA1,
        RX_DATA2,
        RX_DATA3
    } rx_state_e;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_RUN,
        MAC_DRAIN
    } mac_state_e;

endpackage

// ==== hdl/packet_rx.sv ====
// Packet parser for the seven-byte host protocol
// Collects a packet and issues one command strobe per packet

module packet_rx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_rx_valid,
    input  logic [7:0]  i_rx_data,
    output logic [7:0]  o_cmd_byte,
    output logic [7:0]  o_addr,
    output logic [31:0] o_data,
    output logic        o_csr_wr,
    output logic        o_csr_rd,
    output logic        o_buf_wr_a,
    output logic        o_buf_wr_b,
    output logic        o_rd_out,
    output logic        o_start,
    output logic        o_abort,
    output logic        o_status
);

    import accel_pkg::*;

    rx_state_e r_state;

    // ====================
    // Byte position FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_state    <= RX_CMD;
            o_csr_wr   <= 1'b0;
            o_csr_rd   <= 1'b0;
            o_buf_wr_a <= 1'b0;
            o_buf_wr_b <= 1'b0;
            o_rd_out   <= 1'b0;
            o_start    <= 1'b0;
            o_abort    <= 1'b0;
            o_status   <= 1'b0;
        end else begin
            // Strobes last one cycle
            o_csr_wr   <= 1'b0;
            o_csr_rd   <= 1'b0;
            o_buf_wr_a <= 1'b0;
            o_buf_wr_b <= 1'b0;
            o_rd_out   <= 1'b0;
            o_start    <= 1'b0;
            o_abort    <= 1'b0;
            o_status   <= 1'b0;
            if (i_rx_valid) begin
                case (r_state)
                    RX_CMD:    r_state <= RX_ADDR_L;
                    RX_ADDR_L: r_state <= RX_ADDR_H;
                    RX_ADDR_H: r_state <= RX_DATA0;
                    RX_DATA0:  r_state <= RX_DATA1;
                    RX_DATA1:  r_state <= RX_DATA2;
                    RX_DATA2:  r_state <= RX_DATA3;
                    RX_DATA3: begin
                        r_state <= RX_CMD;
                        // Command byte was captured six bytes ago
                        case (cmd_e'(o_cmd_byte[7:4]))
                            CMD_CSR_WR:   o_csr_wr   <= 1'b1;
                            CMD_CSR_RD:   o_csr_rd   <= 1'b1;
                            CMD_BUF_WR_A: o_buf_wr_a <= 1'b1;
                            CMD_BUF_WR_B: o_buf_wr_b <= 1'b1;
                            CMD_RD_OUT:   o_rd_out   <= 1'b1;
                            CMD_START:    o_start    <= 1'b1;
                            CMD_ABORT:    o_abort    <= 1'b1;
                            CMD_STATUS:   o_status   <= 1'b1;
                            default:      ;
                        endcase
                    end
                    default: r_state <= RX_CMD;
                endcase
            end
        end
    end

    // Field capture, upper address byte is not kept
    always_ff @(posedge clk) begin
        if (i_rx_valid) begin
            case (r_state)
                RX_CMD:    o_cmd_byte    <= i_rx_data;
                RX_ADDR_L: o_addr        <= i_rx_data;
                RX_DATA0:  o_data[7:0]   <= i_rx_data;
                RX_DATA1:  o_data[15:8]  <= i_rx_data;
                RX_DATA2:  o_data[23:16] <= i_rx_data;
                RX_DATA3:  o_data[31:24] <= i_rx_data;
                default:   ;
            endcase
        end
    end

endmodule

// ==== hdl/csr_regs.sv ====
// Control registers: K length and completed-run counter
// Read data is registered on the read strobe

module csr_regs #(
    parameter int BUF_AW = accel_pkg::BUF_AW
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_wr,
    input  logic                          i_rd,
    input  logic [7:0]                    i_addr,
    input  logic [accel_pkg::ACC_W-1:0]   i_wdata,
    input  logic                          i_run_done,
    output logic [accel_pkg::ACC_W-1:0]   o_rdata,
    output logic [BUF_AW:0]               o_k_len
);

    import accel_pkg::*;

    // Largest K the buffers can hold
    localparam int K_MAX = 2 ** BUF_AW;

    logic [ACC_W-1:0] r_run_count;

    // ====================
    // Register updates
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_k_len     <= (BUF_AW+1)'(1);
            r_run_count <= '0;
        end else begin
            if (i_wr && (i_addr == CSR_K_LEN)) begin
                // Saturate at buffer depth
                if (i_wdata > ACC_W'(K_MAX)) begin
                    o_k_len <= (BUF_AW+1)'(K_MAX);
                end else begin
                    o_k_len <= i_wdata[BUF_AW:0];
                end
            end
            if (i_run_done) begin
                r_run_count <= r_run_count + 1'b1;
            end
        end
    end

    // Read mux, unmapped addresses read as zero
    always_ff @(posedge clk) begin
        if (i_rd) begin
            case (i_addr)
                CSR_K_LEN:     o_rdata <= ACC_W'(o_k_len);
                CSR_RUN_COUNT: o_rdata <= r_run_count;
                default:       o_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== hdl/operand_buffer.sv ====
// Activation and weight row memories
// One write port each, shared registered read address

module operand_buffer #(
    parameter int N_ROWS = accel_pkg::N_ROWS,
    parameter int N_COLS = accel_pkg::N_COLS,
    parameter int BUF_AW = accel_pkg::BUF_AW
) (
    input  logic                                   clk,
    input  logic                                   i_we_a,
    input  logic                                   i_we_b,
    input  logic [BUF_AW-1:0]                      i_waddr,
    input  logic [accel_pkg::ACC_W-1:0]            i_wdata,
    input  logic [BUF_AW-1:0]                      i_raddr,
    output logic [N_ROWS*accel_pkg::DATA_W-1:0]    o_a_row,
    output logic [N_COLS*accel_pkg::DATA_W-1:0]    o_b_row
);

    import accel_pkg::*;

    localparam int MEM_DEPTH = 2 ** BUF_AW;
    localparam int A_W       = N_ROWS * DATA_W;
    localparam int B_W       = N_COLS * DATA_W;

    logic [A_W-1:0] mem_a [MEM_DEPTH];
    logic [B_W-1:0] mem_b [MEM_DEPTH];

    // Rows take the low bytes of the data word
    always_ff @(posedge clk) begin
        if (i_we_a) begin
            mem_a[i_waddr] <= i_wdata[A_W-1:0];
        end
        if (i_we_b) begin
            mem_b[i_waddr] <= i_wdata[B_W-1:0];
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        o_a_row <= mem_a[i_raddr];
        o_b_row <= mem_b[i_raddr];
    end

endmodule

// ==== hdl/mac_engine.sv ====
// Tile MAC engine with row sequencer
// Accumulates signed outer products of K buffer rows into a 2x2 array

module mac_engine #(
    parameter int N_ROWS = accel_pkg::N_ROWS,
    parameter int N_COLS = accel_pkg::N_COLS,
    parameter int BUF_AW = accel_pkg::BUF_AW
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   i_start,
    input  logic                                   i_abort,
    input  logic [BUF_AW:0]                        i_k_len,
    input  logic [N_ROWS*accel_pkg::DATA_W-1:0]    i_a_row,
    input  logic [N_COLS*accel_pkg::DATA_W-1:0]    i_b_row,
    input  logic [1:0]                             i_sel,
    output logic [BUF_AW-1:0]                      o_raddr,
    output logic [accel_pkg::ACC_W-1:0]            o_acc,
    output logic                                   o_busy,
    output logic                                   o_done
);

    import accel_pkg::*;

    localparam int N_ACC  = N_ROWS * N_COLS;
    localparam int PROD_W = 2 * DATA_W;

    mac_state_e               r_state;
    logic                     r_valid;
    logic                     r_drain;
    logic [BUF_AW:0]          w_k_eff;
    logic                     w_last;
    logic signed [PROD_W-1:0] w_prod [N_ACC];
    logic signed [ACC_W-1:0]  r_acc  [N_ACC];

    // Zero length runs as a single row
    assign w_k_eff = (i_k_len == '0) ? (BUF_AW+1)'(1) : i_k_len;
    assign w_last  = ({1'b0, o_raddr} == (w_k_eff - 1'b1));

    // Products for every (row, col) pair
    always_comb begin
        for (int r = 0; r < N_ROWS; r++) begin
            for (int c = 0; c < N_COLS; c++) begin
                w_prod[r*N_COLS+c] = $signed(i_a_row[r*DATA_W +: DATA_W]) *
                                     $signed(i_b_row[c*DATA_W +: DATA_W]);
            end
        end
    end

    // ====================
    // Sequencer and array
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_state <= MAC_IDLE;
            r_valid <= 1'b0;
            r_drain <= 1'b0;
            o_raddr <= '0;
            o_done  <= 1'b0;
            for (int p = 0; p < N_ACC; p++) begin
                r_acc[p] <= '0;
            end
        end else begin
            o_done <= 1'b0;
            // Read data arrives one cycle after its address
            r_valid <= (r_state == MAC_RUN);

            if (r_valid) begin
                for (int p = 0; p < N_ACC; p++) begin
                    r_acc[p] <= r_acc[p] +
                        {{(ACC_W-PROD_W){w_prod[p][PROD_W-1]}}, w_prod[p]};
                end
            end

            if (i_abort) begin
                r_state <= MAC_IDLE;
                r_valid <= 1'b0;
                for (int p = 0; p < N_ACC; p++) begin
                    r_acc[p] <= '0;
                end
            end else begin
                case (r_state)
                    MAC_IDLE: begin
                        if (i_start) begin
                            r_state <= MAC_RUN;
                            o_raddr <= '0;
                            for (int p = 0; p < N_ACC; p++) begin
                                r_acc[p] <= '0;
                            end
                        end
                    end
                    MAC_RUN: begin
                        if (w_last) begin
                            r_state <= MAC_DRAIN;
                            r_drain <= 1'b0;
                        end else begin
                            o_raddr <= o_raddr + 1'b1;
                        end
                    end
                    MAC_DRAIN: begin
                        // Two cycles to let the last row land
                        r_drain <= 1'b1;
                        if (r_drain) begin
                            r_state <= MAC_IDLE;
                            o_done  <= 1'b1;
                        end
                    end
                    default: r_state <= MAC_IDLE;
                endcase
            end
        end
    end

    assign o_busy = (r_state != MAC_IDLE);
    assign o_acc  = r_acc[i_sel];

endmodule

// ==== hdl/resp_tx.sv ====
// Response sender for register, result and status reads
// Five bytes per response, each byte costs one transmit credit

module resp_tx #(
    parameter int TX_CREDITS_INIT = accel_pkg::TX_CREDITS_INIT
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_csr_rd,
    input  logic                          i_rd_out,
    input  logic                          i_status,
    input  logic [7:0]                    i_cmd_byte,
    input  logic [accel_pkg::ACC_W-1:0]   i_csr_rdata,
    input  logic [accel_pkg::ACC_W-1:0]   i_acc,
    input  logic                          i_busy,
    input  logic                          i_tx_credit,
    output logic                          o_tx_valid,
    output logic [7:0]                    o_tx_data
);

    import accel_pkg::*;

    logic             r_active;
    logic             r_load;
    logic [2:0]       r_idx;
    logic [7:0]       r_credits;
    logic [7:0]       r_cmd;
    logic [ACC_W-1:0] r_word;
    logic             r_is_rd_out;
    logic             r_is_status;
    logic             w_req;
    logic             w_send;
    logic [ACC_W-1:0] w_word;

    assign w_req = i_csr_rd | i_rd_out | i_status;

    // Payload source, sampled the cycle after the request
    assign w_word = r_is_status ? {{(ACC_W-1){1'b0}}, i_busy} :
                    r_is_rd_out ? i_acc : i_csr_rdata;

    assign o_tx_valid = r_active && (r_credits != '0);
    assign w_send     = o_tx_valid;

    always_comb begin
        case (r_idx)
            3'd0:    o_tx_data = r_cmd;
            3'd1:    o_tx_data = r_word[7:0];
            3'd2:    o_tx_data = r_word[15:8];
            3'd3:    o_tx_data = r_word[23:16];
            default: o_tx_data = r_word[31:24];
        endcase
    end

    // ====================
    // Sequencing and credits
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_active  <= 1'b0;
            r_load    <= 1'b0;
            r_idx     <= '0;
            r_credits <= 8'(TX_CREDITS_INIT);
        end else begin
            r_load <= 1'b0;
            // Requests while busy are dropped
            if (!r_active && w_req) begin
                r_active <= 1'b1;
                r_load   <= 1'b1;
                r_idx    <= '0;
            end else if (w_send) begin
                r_idx <= r_idx + 1'b1;
                if (r_idx == 3'd4) begin
                    r_active <= 1'b0;
                end
            end
            case ({i_tx_credit, w_send})
                2'b10:   r_credits <= r_credits + 1'b1;
                2'b01:   r_credits <= r_credits - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!r_active && w_req) begin
            r_cmd       <= i_cmd_byte;
            r_is_rd_out <= i_rd_out;
            r_is_status <= i_status;
        end
        if (r_load) begin
            r_word <= w_word;
        end
    end

endmodule

// ==== hdl/accel_top.sv ====
// Matrix-tile accelerator top level
// Packet parser, registers, operand buffers, MAC engine and response sender

module accel_top #(
    parameter int N_ROWS          = accel_pkg::N_ROWS,
    parameter int N_COLS          = accel_pkg::N_COLS,
    parameter int BUF_AW          = accel_pkg::BUF_AW,
    parameter int TX_CREDITS_INIT = accel_pkg::TX_CREDITS_INIT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_rx_valid,
    input  logic [7:0] i_rx_data,
    output logic       o_tx_valid,
    output logic [7:0] o_tx_data,
    input  logic       i_tx_credit,
    output logic       o_busy,
    output logic       o_done
);

    import accel_pkg::*;

    logic [7:0]              cmd_byte;
    logic [7:0]              addr;
    logic [ACC_W-1:0]        data;
    logic                    csr_wr;
    logic                    csr_rd;
    logic                    buf_wr_a;
    logic                    buf_wr_b;
    logic                    rd_out;
    logic                    start;
    logic                    abort;
    logic                    status;
    logic [ACC_W-1:0]        csr_rdata;
    logic [BUF_AW:0]         k_len;
    logic [BUF_AW-1:0]       raddr;
    logic [N_ROWS*DATA_W-1:0] a_row;
    logic [N_COLS*DATA_W-1:0] b_row;
    logic [ACC_W-1:0]        acc;

    packet_rx u_rx (
        .clk(clk), .rst_n(rst_n),
        .i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data),
        .o_cmd_byte(cmd_byte), .o_addr(addr), .o_data(data),
        .o_csr_wr(csr_wr), .o_csr_rd(csr_rd),
        .o_buf_wr_a(buf_wr_a), .o_buf_wr_b(buf_wr_b),
        .o_rd_out(rd_out), .o_start(start),
        .o_abort(abort), .o_status(status)
    );

    csr_regs #(.BUF_AW(BUF_AW)) u_csr (
        .clk(clk), .rst_n(rst_n),
        .i_wr(csr_wr), .i_rd(csr_rd), .i_addr(addr), .i_wdata(data),
        .i_run_done(o_done), .o_rdata(csr_rdata), .o_k_len(k_len)
    );

    operand_buffer #(.N_ROWS(N_ROWS), .N_COLS(N_COLS), .BUF_AW(BUF_AW)) u_buf (
        .clk(clk), .i_we_a(buf_wr_a), .i_we_b(buf_wr_b),
        .i_waddr(addr[BUF_AW-1:0]), .i_wdata(data),
        .i_raddr(raddr), .o_a_row(a_row), .o_b_row(b_row)
    );

    mac_engine #(.N_ROWS(N_ROWS), .N_COLS(N_COLS), .BUF_AW(BUF_AW)) u_mac (
        .clk(clk), .rst_n(rst_n),
        .i_start(start), .i_abort(abort), .i_k_len(k_len),
        .i_a_row(a_row), .i_b_row(b_row), .i_sel(addr[1:0]),
        .o_raddr(raddr), .o_acc(acc), .o_busy(o_busy), .o_done(o_done)
    );

    resp_tx #(.TX_CREDITS_INIT(TX_CREDITS_INIT)) u_tx (
        .clk(clk), .rst_n(rst_n),
        .i_csr_rd(csr_rd), .i_rd_out(rd_out), .i_status(status),
        .i_cmd_byte(cmd_byte), .i_csr_rdata(csr_rdata), .i_acc(acc),
        .i_busy(o_busy), .i_tx_credit(i_tx_credit),
        .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data)
    );

endmodule

// ==== include/accel_tb_tasks.svh ====
// Testbench helpers for the accelerator byte-stream protocol
// Packet send, response byte capture and the tile reference model

`ifndef ACCEL_TB_TASKS_SVH
`define ACCEL_TB_TASKS_SVH

// Seven bytes back to back, upper address byte always zero
task automatic send_packet(input logic [7:0] cmd, input logic [7:0] addr,
                           input logic [31:0] data);
    logic [7:0] pkt [7];
    int         i;
    pkt[0] = cmd;
    pkt[1] = addr;
    pkt[2] = 8'h00;
    for (i = 0; i < 4; i++) begin
        pkt[3+i] = data[8*i +: 8];
    end
    for (i = 0; i < 7; i++) begin
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_data  <= pkt[i];
    end
    @(posedge clk);
    rx_valid <= 1'b0;
    rx_data  <= 8'h00;
endtask

// Waits for one response byte, optionally handing its credit straight back
task automatic get_byte(input bit ret_credit, input int max_wait,
                        output bit got, output logic [7:0] value);
    int n;
    got   = 1'b0;
    value = 8'h00;
    n     = 0;
    while (!got && n < max_wait) begin
        @(posedge clk);
        tx_credit <= 1'b0;
        n++;
        if (tx_valid) begin
            got   = 1'b1;
            value = tx_data;
            if (ret_credit) begin
                tx_credit <= 1'b1;
            end
        end
    end
endtask

// Full five-byte response with a credit returned per byte
task automatic collect_resp(output logic [7:0] echo, output logic [31:0] word);
    logic [7:0] b [5];
    bit         got;
    int         i;
    for (i = 0; i < 5; i++) begin
        get_byte(1'b1, 100, got, b[i]);
        check_cond(got, "response byte did not arrive within 100 cycles");
    end
    @(posedge clk);
    tx_credit <= 1'b0;
    echo = b[0];
    word = {b[4], b[3], b[2], b[1]};
endtask

// Expected accumulator idx = row * N_COLS + col
function automatic int ref_tile(input int idx, input int k_len);
    int row;
    int col;
    int av;
    int bv;
    int sum;
    row = idx / N_COLS;
    col = idx % N_COLS;
    sum = 0;
    for (int k = 0; k < k_len; k++) begin
        av  = $signed(a_rows[k][row*8 +: 8]);
        bv  = $signed(b_rows[k][col*8 +: 8]);
        sum = sum + av * bv;
    end
    return sum;
endfunction

`endif

// ==== tb/accel_tb.sv ====
// Testbench for the matrix-tile accelerator
// Sends host packets, collects responses and checks them against a reference model

module accel_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ROWS     = 2;
    localparam int N_COLS     = 2;
    localparam int BUF_AW     = 4;
    localparam int TX_CREDITS = 4;
    localparam int MAX_CYCLES = 4000;

    // Strobe spacing of two send_packet calls in a row
    localparam int PKT_CYCLES = 8;

    // Command type in the upper nibble
    localparam logic [7:0] CSR_WR = 8'h00;
    localparam logic [7:0] CSR_RD = 8'h10;
    localparam logic [7:0] WR_A   = 8'h20;
    localparam logic [7:0] WR_B   = 8'h30;
    localparam logic [7:0] RD_OUT = 8'h40;
    localparam logic [7:0] START  = 8'h50;
    localparam logic [7:0] ABORT  = 8'h60;
    localparam logic [7:0] STATUS = 8'h70;

    localparam logic [7:0] K_LEN_ADDR   = 8'h00;
    localparam logic [7:0] RUN_CNT_ADDR = 8'h01;

    logic       clk;
    logic       rst_n;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       tx_credit;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       busy;
    logic       done;

    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          run_count_exp = 0;
    logic [15:0] a_rows [16];
    logic [15:0] b_rows [16];

    // Pending comparisons for the compare process
    string       name_q [$];
    logic [31:0] exp_q  [$];
    logic [31:0] act_q  [$];

    accel_top #(
        .N_ROWS(N_ROWS), .N_COLS(N_COLS), .BUF_AW(BUF_AW), .TX_CREDITS_INIT(TX_CREDITS)
    ) dut0 (
        .clk(clk), .rst_n(rst_n),
        .i_rx_valid(rx_valid), .i_rx_data(rx_data),
        .o_tx_valid(tx_valid), .o_tx_data(tx_data),
        .i_tx_credit(tx_credit), .o_busy(busy), .o_done(done)
    );

    `include "accel_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // Checking
    // ====================
    task automatic queue_check(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        name_q.push_back(name);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
    endtask

    task automatic check_cond(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    initial begin : compare_proc
        string       name;
        logic [31:0] exp_v;
        logic [31:0] act_v;
        forever begin
            @(posedge clk);
            while (act_q.size() > 0) begin
                name  = name_q.pop_front();
                exp_v = exp_q.pop_front();
                act_v = act_q.pop_front();
                checks++;
                assert (act_v === exp_v) else begin
                    $display("MISMATCH %s: expected 0x%08h, actual 0x%08h",
                             name, exp_v, act_v);
                    errors++;
                end
            end
        end
    end

    task automatic report_test(input string name, input int base);
        while (act_q.size() > 0) begin
            @(posedge clk);
        end
        $display("Test %-20s finished with %0d errors", name, errors - base);
    endtask

    // ====================
    // Sequence helpers
    // ====================
    task automatic read_and_check(input string name, input logic [7:0] cmd,
                                  input logic [7:0] addr, input logic [31:0] exp_word);
        logic [7:0]  echo;
        logic [31:0] word;
        send_packet(cmd, addr, $random(seed));
        collect_resp(echo, word);
        queue_check({name, "_echo"}, {24'h0, cmd}, {24'h0, echo});
        queue_check(name, exp_word, word);
    endtask

    // Cycles counted from the edge that raised the start strobe plus one
    task automatic wait_done(output int n, output bit busy_early);
        bit seen;
        seen       = 1'b0;
        busy_early = 1'b0;
        n          = 0;
        while (!seen && n < 100) begin
            @(posedge clk);
            n++;
            if (n == 2) begin
                busy_early = busy;
            end
            if (done) begin
                seen = 1'b1;
            end
        end
        check_cond(seen, "done pulse did not arrive within 100 cycles");
        check_cond(!busy, "busy still high when done pulsed");
    endtask

    task automatic count_done(input int cycles, output int n);
        n = 0;
        repeat (cycles) begin
            @(posedge clk);
            if (done) begin
                n++;
            end
        end
    endtask

    task automatic count_bytes(input int cycles, output int n, output logic [7:0] last);
        n    = 0;
        last = 8'h00;
        repeat (cycles) begin
            @(posedge clk);
            if (tx_valid) begin
                n++;
                last = tx_data;
            end
        end
    endtask

    task automatic give_credit();
        @(posedge clk);
        tx_credit <= 1'b1;
        @(posedge clk);
        tx_credit <= 1'b0;
    endtask

    // ====================
    // Tests
    // ====================
    task automatic csr_access();
        int         base;
        int         k;
        logic [7:0] rd_cmd;
        base   = errors;
        k      = ($random(seed) & 15) + 1;
        rd_cmd = CSR_RD | 8'($random(seed) & 15);
        read_and_check("k_len_reset", rd_cmd, K_LEN_ADDR, 32'd1);
        send_packet(CSR_WR, K_LEN_ADDR, 32'(k));
        read_and_check("k_len_rw", rd_cmd, K_LEN_ADDR, 32'(k));
        send_packet(CSR_WR, K_LEN_ADDR, 32'd200);
        read_and_check("k_len_saturate", rd_cmd, K_LEN_ADDR, 32'd16);
        send_packet(CSR_WR, RUN_CNT_ADDR, 32'd99);
        read_and_check("run_count_ro", rd_cmd, RUN_CNT_ADDR, 32'd0);
        read_and_check("unmapped_addr", rd_cmd, 8'h05, 32'd0);
        report_test("csr_access", base);
    endtask

    task automatic tile_product();
        int          base;
        int          i;
        int          n;
        bit          busy_early;
        logic [31:0] a;
        logic [31:0] b;
        base = errors;
        for (i = 0; i < 16; i++) begin
            a         = $random(seed);
            b         = $random(seed);
            a_rows[i] = a[15:0];
            b_rows[i] = b[15:0];
            send_packet(WR_A, 8'(i), a);
            send_packet(WR_B, 8'(i), b);
        end
        send_packet(CSR_WR, K_LEN_ADDR, 32'd5);
        send_packet(START, 8'h00, 32'h0);
        wait_done(n, busy_early);
        check_cond(busy_early, "busy did not rise the cycle after START");
        queue_check("done_latency", 32'(5 + 3), 32'(n - 1));
        run_count_exp++;
        for (i = 0; i < 4; i++) begin
            read_and_check($sformatf("result_%0d", i), RD_OUT, 8'(i), ref_tile(i, 5));
        end
        report_test("tile_product", base);
    endtask

    task automatic run_counting();
        int base;
        int n;
        bit busy_early;
        base = errors;
        read_and_check("run_count_one", CSR_RD, RUN_CNT_ADDR, 32'(run_count_exp));
        send_packet(CSR_WR, K_LEN_ADDR, 32'd8);
        send_packet(START, 8'h00, 32'h0);
        // Second START lands while the first run is still going
        send_packet(START, 8'h00, 32'h0);
        wait_done(n, busy_early);
        // Done still follows the first START by K_LEN+3 cycles
        queue_check("first_run_latency", 32'(8 + 3), 32'(n - 1 + PKT_CYCLES));
        count_done(20, n);
        queue_check("extra_done", 32'd0, 32'(n));
        run_count_exp++;
        read_and_check("run_count_two", CSR_RD, RUN_CNT_ADDR, 32'(run_count_exp));
        report_test("run_counting", base);
    endtask

    task automatic status_polling();
        int base;
        int n;
        bit busy_early;
        base = errors;
        send_packet(CSR_WR, K_LEN_ADDR, 32'd16);
        send_packet(START, 8'h00, 32'h0);
        read_and_check("status_busy", STATUS, 8'h00, 32'd1);
        wait_done(n, busy_early);
        run_count_exp++;
        read_and_check("status_idle", STATUS, 8'h00, 32'd0);
        report_test("status_polling", base);
    endtask

    task automatic abort_run();
        int base;
        int i;
        int n;
        base = errors;
        send_packet(START, 8'h00, 32'h0);
        send_packet(ABORT, 8'h00, 32'h0);
        @(posedge clk);
        @(posedge clk);
        check_cond(!busy, "busy did not drop the cycle after ABORT");
        count_done(40, n);
        queue_check("abort_done", 32'd0, 32'(n));
        for (i = 0; i < 4; i++) begin
            read_and_check($sformatf("abort_result_%0d", i), RD_OUT, 8'(i), 32'd0);
        end
        read_and_check("abort_run_count", CSR_RD, RUN_CNT_ADDR, 32'(run_count_exp));
        report_test("abort_run", base);
    endtask

    task automatic credit_backpressure();
        int         base;
        int         i;
        int         n;
        bit         got;
        logic [7:0] resp [5];
        logic [7:0] last;
        base = errors;
        // First response spends every credit and stalls on its last byte
        send_packet(CSR_RD, RUN_CNT_ADDR, 32'h0);
        for (i = 0; i < TX_CREDITS; i++) begin
            get_byte(1'b0, 50, got, resp[i]);
            check_cond(got, "byte not sent while credits remained");
        end
        count_bytes(50, n, last);
        queue_check("credit_hold", 32'd0, 32'(n));
        give_credit();
        get_byte(1'b0, 20, got, resp[4]);
        check_cond(got, "returned credit did not release the pending byte");
        queue_check("credit_resp1_echo", {24'h0, CSR_RD}, {24'h0, resp[0]});
        queue_check("credit_resp1", 32'(run_count_exp), {resp[4], resp[3], resp[2], resp[1]});

        // Second response starts with no credits at all
        send_packet(CSR_RD | 8'h03, K_LEN_ADDR, 32'h0);
        count_bytes(50, n, last);
        queue_check("credit_hold_empty", 32'd0, 32'(n));
        give_credit();
        count_bytes(20, n, resp[0]);
        queue_check("credit_single_byte", 32'd1, 32'(n));
        for (i = 1; i < 5; i++) begin
            give_credit();
            get_byte(1'b0, 20, got, resp[i]);
            check_cond(got, "returned credit did not release a byte");
        end
        queue_check("credit_resp2_echo", {24'h0, CSR_RD | 8'h03}, {24'h0, resp[0]});
        queue_check("credit_resp2", 32'd16, {resp[4], resp[3], resp[2], resp[1]});

        repeat (TX_CREDITS) give_credit();
        read_and_check("credit_restored", CSR_RD, K_LEN_ADDR, 32'd16);
        report_test("credit_backpressure", base);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin : main_seq
        rst_n     = 1'b0;
        rx_valid  = 1'b0;
        rx_data   = 8'h00;
        tx_credit = 1'b0;
        seed      = 32'h86bdf8ef;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        csr_access();
        tile_product();
        run_counting();
        status_polling();
        abort_run();
        credit_backpressure();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Run limit covers all tests with margin
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: simulation did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hdl/accel_pkg.sv
hdl/packet_rx.sv
hdl/csr_regs.sv
hdl/operand_buffer.sv
hdl/mac_engine.sv
hdl/resp_tx.sv
hdl/accel_top.sv
tb/accel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module accel_tb -f flist.f -o accel_sim \
    && ./obj_dir/accel_sim | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -q "Done: no errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
